//--- common/vsa_consts.svh
// width, depth and timeout constants for the vsa subsystem, included by the package and the RTL
`ifndef VSA_CONSTS_SVH
`define VSA_CONSTS_SVH

// datapath and register width
`define VSA_DATA_W 5

// every instruction is one 12-bit word
`define VSA_INSTR_W 12

// program counter, steps by 2 per instruction
`define VSA_PC_W 5

// data RAM words, one per 5-bit address
`define VSA_DMEM_DEPTH 32

// R0 plus three general-purpose registers
`define VSA_REG_COUNT 4

// cycles a master may wait for ack before a bus is considered hung
`define VSA_BUS_TIMEOUT 64

`endif

//--- common/vsaPkg.sv
// shared types of the vsa subsystem, referenced by scoped name from the core, RAM and top level
`include "vsa_consts.svh"

package vsaPkg;

    typedef logic [`VSA_DATA_W-1:0]             dataT;   // operand, register value, data address
    typedef logic [`VSA_INSTR_W-1:0]            instrT;  // raw instruction word
    typedef logic [`VSA_PC_W-1:0]               pcT;     // instruction address
    typedef logic [$clog2(`VSA_REG_COUNT)-1:0]  regIdxT; // register file index

    // major opcode, ir[11:9]
    typedef enum logic [2:0] {
        opLw   = 3'd0,
        opSw   = 3'd1,
        opBeqz = 3'd2,
        opAlu  = 3'd3, // R-format, function in ir[2:0]
        opAddi = 3'd4,
        opSubi = 3'd5
    } opcodeT;

    // R-format function field
    typedef enum logic [2:0] {
        fnAdd = 3'd0,
        fnSub = 3'd1,
        fnAnd = 3'd2,
        fnOr  = 3'd3,
        fnXor = 3'd4,
        fnNot = 3'd5,
        fnSrl = 3'd6,
        fnSra = 3'd7
    } aluFuncT;

    // one pass through these per instruction
    typedef enum logic [2:0] {
        stFetch,
        stDecode,
        stExecute,
        stMemory,
        stWriteBack
    } ctrlStateT;

    // wishbone classic master request
    typedef struct packed {
        logic cyc;
        logic stb;
        logic we;
        dataT adr;
        dataT dat;
    } wbReqT;

    // data slave response
    typedef struct packed {
        logic ack;
        dataT dat;
    } wbRspT;

    // instruction slave response, full word
    typedef struct packed {
        logic  ack;
        instrT dat;
    } instrRspT;

    // completed instruction as seen at write-back
    typedef struct packed {
        logic   valid;
        pcT     pc;
        instrT  instr;
        logic   regWe;
        regIdxT regIdx;
        dataT   regData;
        logic   memWe;
        dataT   memAddr;
        dataT   memData;
        pcT     nextPc;
    } retireT;

endpackage

//--- vsaCore/vsaAlu.sv
// execute-stage ALU instantiated by the vsa core to give one result and a branch flag per opcode
`timescale 1ns/1ps
`include "vsa_consts.svh"

module vsaAlu (
    input  vsaPkg::opcodeT  opcode,
    input  vsaPkg::aluFuncT func,
    input  vsaPkg::dataT    a,      // first operand from fld1
    input  vsaPkg::dataT    b,      // second operand from fld2
    input  vsaPkg::dataT    imm,    // raw I-format immediate
    input  vsaPkg::pcT      npc,    // pc + 2 of this instruction
    output vsaPkg::dataT    result,
    output logic            zero    // branch condition for BEQZ only
);

    vsaPkg::dataT branchOffset;
    vsaPkg::dataT funcResult;

    // word offset is the low four immediate bits times two
    assign branchOffset = {imm[3:0], 1'b0};

    // R-format group where NOT and the shifts ignore b
    always_comb begin
        unique case (func)
            vsaPkg::fnAdd: funcResult = a + b;   // wraps mod 32
            vsaPkg::fnSub: funcResult = a - b;
            vsaPkg::fnAnd: funcResult = a & b;
            vsaPkg::fnOr:  funcResult = a | b;
            vsaPkg::fnXor: funcResult = a ^ b;
            vsaPkg::fnNot: funcResult = ~a;
            vsaPkg::fnSrl: funcResult = {1'b0, a[`VSA_DATA_W-1:1]};
            vsaPkg::fnSra: funcResult = {a[`VSA_DATA_W-1], a[`VSA_DATA_W-1:1]};
            default:       funcResult = '0;
        endcase
    end

    always_comb begin
        zero = 1'b0;
        case (opcode)
            vsaPkg::opLw,
            vsaPkg::opSw,
            vsaPkg::opAddi: result = a + imm;    // effective address or sum
            vsaPkg::opSubi: result = a - imm;
            vsaPkg::opAlu:  result = funcResult;
            vsaPkg::opBeqz: begin
                result = vsaPkg::dataT'(npc) + branchOffset; // branch target
                zero   = (a == '0);
            end
            default:        result = '0;         // undefined opcodes 6 and 7
        endcase
    end

endmodule

//--- vsaCore/vsaCore.sv
// multicycle vsa core, fetch to write-back per instruction over two wishbone masters
`timescale 1ns/1ps
`include "vsa_consts.svh"

module vsaCore (
    input  logic             clock,
    input  logic             rstN,
    output vsaPkg::wbReqT    imemReq,   // instruction fetch, read only
    input  vsaPkg::instrRspT imemRsp,
    output vsaPkg::wbReqT    dmemReq,   // loads and stores
    input  vsaPkg::wbRspT    dmemRsp,
    output vsaPkg::retireT   retire     // valid for the write-back cycle
);

    vsaPkg::ctrlStateT state;
    vsaPkg::dataT      regFile [`VSA_REG_COUNT]; // entry 0 never written
    vsaPkg::pcT        pc;          // address of the next fetch
    vsaPkg::pcT        npc;         // pc + 2
    vsaPkg::pcT        instrPc;     // address of the instruction in flight
    vsaPkg::instrT     ir;
    vsaPkg::dataT      a;
    vsaPkg::dataT      b;
    vsaPkg::dataT      aluOut;
    vsaPkg::dataT      lmd;         // load data
    logic              cond;        // branch taken
    logic              imemCyc;     // fetch cycle open
    logic              dmemCyc;     // data cycle open

    // instruction fields
    // R-format: op(3) fld1(2) fld2(2) fld3(2) func(3)
    // I-format: op(3) fld1(2) fld2(2) imm(5)
    vsaPkg::opcodeT  opcode;
    vsaPkg::aluFuncT func;
    vsaPkg::regIdxT  fld1;
    vsaPkg::regIdxT  fld2;
    vsaPkg::regIdxT  fld3;
    vsaPkg::dataT    imm;

    logic            memRef;
    logic            isLoad;
    logic            isStore;
    logic            isBranch;
    logic            writesReg;
    vsaPkg::regIdxT  destIdx;
    logic            wbWe;          // register write, R0 filtered
    vsaPkg::dataT    wbData;

    vsaPkg::dataT    aluResult;
    logic            aluZero;

    assign opcode = vsaPkg::opcodeT'(ir[11:9]);
    assign fld1   = ir[8:7];
    assign fld2   = ir[6:5];
    assign fld3   = ir[4:3];
    assign func   = vsaPkg::aluFuncT'(ir[2:0]);
    assign imm    = ir[4:0];

    assign isLoad    = (opcode == vsaPkg::opLw);
    assign isStore   = (opcode == vsaPkg::opSw);
    assign isBranch  = (opcode == vsaPkg::opBeqz);
    assign memRef    = isLoad || isStore;
    assign writesReg = (opcode == vsaPkg::opAlu) || (opcode == vsaPkg::opAddi)
                    || (opcode == vsaPkg::opSubi) || isLoad;

    // R-format writes fld3, I-format fld2
    assign destIdx = (opcode == vsaPkg::opAlu) ? fld3 : fld2;
    assign wbWe    = writesReg && (destIdx != '0);
    assign wbData  = isLoad ? lmd : aluOut;

    vsaAlu vsaAlu_inst (
        .opcode (opcode),
        .func   (func),
        .a      (a),
        .b      (b),
        .imm    (imm),
        .npc    (npc),
        .result (aluResult),
        .zero   (aluZero)
    );

    // both masters hold address and data from registers for the whole cycle
    assign imemReq.cyc = imemCyc;
    assign imemReq.stb = imemCyc;
    assign imemReq.we  = 1'b0;
    assign imemReq.adr = vsaPkg::dataT'(pc);  // pc zero-extended
    assign imemReq.dat = '0;

    assign dmemReq.cyc = dmemCyc;
    assign dmemReq.stb = dmemCyc;
    assign dmemReq.we  = dmemCyc && isStore;
    assign dmemReq.adr = aluOut;              // base + imm
    assign dmemReq.dat = b;

    always_ff @(posedge clock) begin
        if (!rstN) begin
            state   <= vsaPkg::stFetch;
            pc      <= '0;
            npc     <= '0;
            instrPc <= '0;
            ir      <= '0;
            a       <= '0;
            b       <= '0;
            aluOut  <= '0;
            lmd     <= '0;
            cond    <= 1'b0;
            imemCyc <= 1'b0;
            dmemCyc <= 1'b0;
            for (int i = 0; i < `VSA_REG_COUNT; i++) begin
                regFile[i] <= '0;
            end
        end else begin
            unique case (state)
                vsaPkg::stFetch: begin
                    if (!imemCyc) begin
                        imemCyc <= 1'b1;  // only right after reset
                    end else if (imemRsp.ack) begin
                        imemCyc <= 1'b0;  // cycle closes after ack
                        ir      <= imemRsp.dat;
                        npc     <= pc + vsaPkg::pcT'(2);
                        instrPc <= pc;
                        state   <= vsaPkg::stDecode;
                    end
                end
                vsaPkg::stDecode: begin
                    a     <= regFile[fld1];
                    b     <= regFile[fld2];
                    state <= vsaPkg::stExecute;
                end
                vsaPkg::stExecute: begin
                    aluOut  <= aluResult;
                    cond    <= aluZero;
                    dmemCyc <= memRef;    // open data cycle on entry to memory
                    state   <= vsaPkg::stMemory;
                end
                vsaPkg::stMemory: begin
                    if (!memRef) begin
                        // branch resolves here, otherwise plain pc + 2
                        pc    <= (isBranch && cond) ? vsaPkg::pcT'(aluOut) : npc;
                        state <= vsaPkg::stWriteBack;
                    end else if (dmemRsp.ack) begin
                        dmemCyc <= 1'b0;
                        if (isLoad) begin
                            lmd <= dmemRsp.dat;
                        end
                        pc    <= npc;
                        state <= vsaPkg::stWriteBack;
                    end
                end
                vsaPkg::stWriteBack: begin
                    if (wbWe) begin
                        regFile[destIdx] <= wbData;
                    end
                    imemCyc <= 1'b1;      // next fetch starts with the state
                    state   <= vsaPkg::stFetch;
                end
                default: state <= vsaPkg::stFetch;
            endcase
        end
    end

    // retire record, fields without their enable read as zero
    always_comb begin
        retire.valid   = (state == vsaPkg::stWriteBack);
        retire.pc      = instrPc;
        retire.instr   = ir;
        retire.regWe   = wbWe;
        retire.regIdx  = wbWe ? destIdx : '0;
        retire.regData = wbWe ? wbData : '0;
        retire.memWe   = isStore;
        retire.memAddr = isStore ? aluOut : '0;
        retire.memData = isStore ? b : '0;
        retire.nextPc  = pc;              // already updated in memory state
    end

endmodule

//--- src/vsaDataRam.sv
// on-chip data RAM for the vsa core, wishbone classic slave with a registered one-cycle ack
`timescale 1ns/1ps
`include "vsa_consts.svh"

module vsaDataRam (
    input  logic          clock,
    input  logic          rstN,
    input  vsaPkg::wbReqT req,
    output vsaPkg::wbRspT rsp
);

    vsaPkg::dataT mem [`VSA_DMEM_DEPTH]; // full 5-bit address space
    vsaPkg::dataT rdData;
    logic         ack;
    logic         take;                  // new access this cycle

    // a strobe seen while ack is low, so ack never repeats for one request
    assign take = req.cyc && req.stb && !ack;

    always_ff @(posedge clock) begin
        if (!rstN) begin
            ack <= 1'b0;
        end else begin
            ack <= take; // single-cycle pulse
        end
    end

    // write lands at the edge that raises ack
    always_ff @(posedge clock) begin
        if (take) begin
            if (req.we) begin
                mem[req.adr] <= req.dat;
            end
            rdData <= mem[req.adr]; // old word on a write
        end
    end

    assign rsp.ack = ack;
    assign rsp.dat = rdData;       // valid together with ack

endmodule

//--- src/vsaSystem.sv
// vsa subsystem top level, core plus data RAM, instruction bus and retire record brought out
`timescale 1ns/1ps

module vsaSystem (
    input  logic             clock,
    input  logic             rstN,
    output vsaPkg::wbReqT    imemReq,  // served by external instruction memory
    input  vsaPkg::instrRspT imemRsp,
    output vsaPkg::retireT   retire
);

    // data bus stays on chip
    vsaPkg::wbReqT dmemReq;
    vsaPkg::wbRspT dmemRsp;

    vsaCore vsaCore_inst (
        .clock   (clock),
        .rstN    (rstN),
        .imemReq (imemReq),
        .imemRsp (imemRsp),
        .dmemReq (dmemReq),
        .dmemRsp (dmemRsp),
        .retire  (retire)
    );

    vsaDataRam vsaDataRam_inst (
        .clock (clock),
        .rstN  (rstN),
        .req   (dmemReq),
        .rsp   (dmemRsp)
    );

endmodule

//--- test/vsaSystemTb.sv
// vsa subsystem testbench that serves instruction words from the pattern file and checks retire records
`timescale 1ns/1ps

module vsaSystemTb;

    localparam int          progWords   = 16;
    localparam int          maxEntries  = 64;
    localparam int          clockPeriod = 10;
    localparam logic [63:0] endMarker   = '1;

    logic             clock;
    logic             rstN;
    vsaPkg::wbReqT    imemReq;
    vsaPkg::instrRspT imemRsp;
    vsaPkg::retireT   retire;

    logic [63:0] patterns [maxEntries]; // program words followed by packed records
    int          recordCount    = 0;
    int          retiredCount   = 0;
    int          mismatchErrors = 0;
    int          protocolErrors = 0;
    int          otherErrors    = 0;
    logic        patternsLoaded = 1'b0;

    vsaSystem vsaSystem_inst (
        .clock   (clock),
        .rstN    (rstN),
        .imemReq (imemReq),
        .imemRsp (imemRsp),
        .retire  (retire)
    );

    initial begin
        clock = 1'b0;
        forever #(clockPeriod / 2) clock = ~clock;
    end

    function automatic vsaPkg::retireT unpackRecord(input int index);
        logic [63:0]    word;
        vsaPkg::retireT rec;
        word        = patterns[progWords + index];
        rec.valid   = 1'b1;
        rec.pc      = word[60:56];
        rec.instr   = word[55:44];
        rec.regWe   = word[40];
        rec.regIdx  = word[37:36];
        rec.regData = word[32:28];
        rec.memWe   = word[24];
        rec.memAddr = word[20:16];
        rec.memData = word[12:8];
        rec.nextPc  = word[4:0];
        return rec;
    endfunction

    task automatic reportField(input string name, input logic [11:0] expVal,
                               input logic [11:0] actVal);
        if (expVal !== actVal) begin
            $display("MISMATCH retire.%s record %0d: expected 0x%0h, actual 0x%0h",
                     name, retiredCount, expVal, actVal);
            mismatchErrors++;
        end
    endtask

    task automatic checkRetire(input vsaPkg::retireT expRec, input vsaPkg::retireT actRec);
        reportField("pc", 12'(expRec.pc), 12'(actRec.pc));
        reportField("instr", expRec.instr, actRec.instr);
        reportField("regWe", 12'(expRec.regWe), 12'(actRec.regWe));
        reportField("regIdx", 12'(expRec.regIdx), 12'(actRec.regIdx));
        reportField("regData", 12'(expRec.regData), 12'(actRec.regData));
        reportField("memWe", 12'(expRec.memWe), 12'(actRec.memWe));
        reportField("memAddr", 12'(expRec.memAddr), 12'(actRec.memAddr));
        reportField("memData", 12'(expRec.memData), 12'(actRec.memData));
        reportField("nextPc", 12'(expRec.nextPc), 12'(actRec.nextPc));
    endtask

    // request must stay put until ack
    task automatic checkFetchHeld(input vsaPkg::wbReqT req, input vsaPkg::wbReqT heldReq);
        if (!req.cyc || !req.stb) begin
            $display("instruction request at 0x%0h dropped before its ack", heldReq.adr);
            protocolErrors++;
        end
        if (req.we) begin
            $display("write enable raised on the read-only instruction bus");
            protocolErrors++;
        end
        if (req.adr !== heldReq.adr) begin
            $display("MISMATCH imemReq.adr: expected 0x%0h, actual 0x%0h",
                     heldReq.adr, req.adr);
            protocolErrors++;
        end
        if (req.dat !== heldReq.dat) begin
            $display("MISMATCH imemReq.dat: expected 0x%0h, actual 0x%0h",
                     heldReq.dat, req.dat);
            protocolErrors++;
        end
    endtask

    task automatic printErrorCounts();
        $display("errors: %0d mismatch, %0d protocol, %0d other, %0d of %0d records retired",
                 mismatchErrors, protocolErrors, otherErrors, retiredCount, recordCount);
    endtask

    // instruction memory with 0 to 3 wait states per fetch
    initial begin : instrMemory
        vsaPkg::wbReqT heldReq;
        int            waits;
        int            wordIdx;
        forever begin
            @(posedge clock);
            #1;
            if (rstN && imemReq.cyc && imemReq.stb) begin
                heldReq = imemReq;
                checkFetchHeld(imemReq, heldReq);
                waits = $urandom_range(3, 0);
                repeat (waits) begin
                    @(posedge clock);
                    #1;
                    checkFetchHeld(imemReq, heldReq);
                end
                wordIdx     = int'(heldReq.adr) >> 1;  // pc steps by 2
                imemRsp.ack = 1'b1;
                imemRsp.dat = patterns[wordIdx][11:0];
                @(posedge clock);
                #1;
                imemRsp.ack = 1'b0;                    // one-cycle ack
                imemRsp.dat = '0;
                if (imemReq.cyc || imemReq.stb) begin
                    $display("instruction bus cycle still open in the cycle after its ack");
                    protocolErrors++;
                end
            end
        end
    end

    // records settle well before the falling edge
    always @(negedge clock) begin
        if (rstN && retire.valid && retiredCount < recordCount) begin
            checkRetire(unpackRecord(retiredCount), retire);
            retiredCount++;
        end
    end

    initial begin : mainFlow
        int idx;
        void'($urandom(32'h3f19));
        rstN    = 1'b0;
        imemRsp = '0;
        $readmemh("test/vsaPatterns.mem", patterns);
        idx = progWords;
        while (idx < maxEntries && patterns[idx] != endMarker) begin
            recordCount++;
            idx++;
        end
        patternsLoaded = 1'b1;
        if (recordCount == 0) begin
            $display("pattern file holds no expected records");
            otherErrors++;
        end
        repeat (8) @(posedge clock);
        #1;
        rstN = 1'b1;
        wait (retiredCount == recordCount);
        repeat (4) @(posedge clock);
        printErrorCounts();
        if (mismatchErrors + protocolErrors + otherErrors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        int limitCycles;
        wait (patternsLoaded);
        limitCycles = recordCount * 5 * 10 + 200; // 5 states per record times 10 for bus waits
        repeat (limitCycles) @(posedge clock);
        $display("timeout after %0d cycles, core stopped retiring instructions", limitCycles);
        otherErrors++;
        printErrorCounts();
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- vsaSystem.f
+incdir+common
common/vsaPkg.sv
vsaCore/vsaAlu.sv
vsaCore/vsaCore.sv
src/vsaDataRam.sv
src/vsaSystem.sv
test/vsaSystemTb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0 --timescale 1ns/1ps
LINTFLAGS := --lint-only --timing --timescale 1ns/1ps
TOP       := vsaSystemTb
RTL_TOP   := vsaSystem
FILELIST  := vsaSystem.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# the log decides the result, not the simulator exit code
run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- test/vsaPatterns.mem
// words 0..15 program, word n served at pc 2n
// then records pc(2) instr(3) regWe(1) regIdx(1) regData(2) memWe(1) memAddr(2) memData(2) nextPc(2)
825 A43 6D9 6DA // addi r1, subi r2, sub, and
6DB 6DC 6DD 73E // or, xor, not, srl
73F 2E4 049 6C0 // sra, sw, lw r2, add to r0
6D8 BE1 581 40D // add wraps to 3, loop: subi r3, beqz r3, beqz r0 back
0082511050000002
02A43121D0000004
046D913080000006
066DA13050000008
086DB131D000000A
0A6DC1318000000C
0C6DD131A000000E
0E73E130E0000010
1073F131E0000012
122E400001091E14
14049121E0000016
166C000000000018
186D81303000001A
1ABE11302000001C
1C5810000000001E
1E40D0000000001A
1ABE11301000001C
1C5810000000001E
1E40D0000000001A
1ABE11300000001C
1C58100000000000
0082511050000002
// end of records
FFFFFFFFFFFFFFFF
